//--- filelist.f
src/ecc_mem_pkg.sv
src/secded_39_32_enc.sv
src/secded_39_32_dec.sv
src/sram_bank.sv
src/ecc_bank_wrap.sv
src/bank_arbiter.sv
src/ecc_scrubber.sv
src/ecc_mem_top.sv
dv/tb_ecc_mem_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
TOP       := tb_ecc_mem_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@grep -q "TESTBENCH PASSED" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- dv/tb_ecc_mem_top.sv
`timescale 1ns/1ps
// Directed testbench for the ECC data memory
// Checks full and partial stores, SECDED correction and background scrubbing
module tb_ecc_mem_top;
  import ecc_mem_pkg::*;

  localparam int NumT1      = 16;
  localparam int NumT3      = 8;
  localparam int NumT4      = 4;
  localparam int MaxGntWait = 4;
  localparam int OpCycles   = MaxGntWait + 4;  // Upper bound for one core access
  localparam int ScrubBound = 4 * NumWords * (ScrubInterval + 4);
  localparam int NumOps     = 2 * NumT1 + 3 * 16 + 3 * NumT3 + 3 * NumT4 + 8;
  localparam int TimeoutCycles = 16 + OpCycles * NumOps + ScrubBound
                               + 2 * ScrubInterval + 64;

  logic                  clk_i;
  logic                  rst_ni;
  mem_req_t              core_req;
  mem_rsp_t              core_rsp;
  logic [CountWidth-1:0] scrub_count;

  logic [DataWidth-1:0] model [NumWords];  // Expected contents per word
  integer               seed;

  ecc_mem_top ecc_mem_top_i (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .core_req_i    ( core_req    ),
    .core_rsp_o    ( core_rsp    ),
    .scrub_count_o ( scrub_count )
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_data(input string name, input logic [DataWidth-1:0] exp,
                            input logic [DataWidth-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input logic [CountWidth-1:0] exp,
                             input logic [CountWidth-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Enabled bytes come from the new word, the rest stay
  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_word,
                                                       input logic [DataWidth-1:0] new_word,
                                                       input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] res;
    res = old_word;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // Read of word 0 keeps the core port busy so the scrubber stays out
  function automatic mem_req_t idle_req();
    mem_req_t r;
    r       = '0;
    r.req   = 1'b1;
    r.be    = '1;
    return r;
  endfunction

  task automatic flip_bit(input logic [AddrWidth-1:0] word, input int unsigned pos);
    logic [CodeWidth-1:0] code;
    code      = ecc_mem_top_i.ecc_bank_wrap_i.sram_bank_i.mem[word];
    code[pos] = ~code[pos];
    ecc_mem_top_i.ecc_bank_wrap_i.sram_bank_i.mem[word] = code;
  endtask

  // Returns just after the falling edge of the cycle after the grant
  task automatic access(input logic we, input logic [BeWidth-1:0] be,
                        input logic [AddrWidth-1:0] word, input logic [DataWidth-1:0] wdata);
    mem_req_t r;
    int       waits;
    waits = 0;
    r       = '0;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.wdata = wdata;
    r.addr[AddrWidth+1:2] = word;
    @(negedge clk_i);
    core_req = r;
    #1;
    while (!core_rsp.gnt) begin
      waits++;
      if (waits > MaxGntWait) stop_on_error("core request was never granted");
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    core_req = idle_req();
    #1;
  endtask

  task automatic write_full(input logic [AddrWidth-1:0] word, input logic [DataWidth-1:0] data);
    access(1'b1, '1, word, data);
    model[word] = data;
  endtask

  task automatic read_check(input string name, input logic [AddrWidth-1:0] word,
                            input logic exp_corr, input logic exp_uncorr, input logic cmp_data);
    access(1'b0, '1, word, '0);
    if (cmp_data) check_data({name, " rdata"}, model[word], core_rsp.rdata);
    check_flag({name, " err_corr"}, exp_corr, core_rsp.err_corr);
    check_flag({name, " err_uncorr"}, exp_uncorr, core_rsp.err_uncorr);
  endtask

  task automatic test_full_words();
    logic [AddrWidth-1:0] words [NumT1];
    for (int i = 0; i < NumT1; i++) begin
      words[i] = AddrWidth'(rand_below(NumWords));
      write_full(words[i], $random(seed));
    end
    for (int i = 0; i < NumT1; i++) begin
      read_check($sformatf("full_words[%0d]", i), words[i], 1'b0, 1'b0, 1'b1);
    end
  endtask

  task automatic test_partial_writes();
    logic [AddrWidth-1:0] word;
    logic [DataWidth-1:0] data;
    for (int be = 0; be < 16; be++) begin
      word = AddrWidth'(rand_below(NumWords));
      write_full(word, $random(seed));
      check_flag($sformatf("partial[%0d] gnt after full write", be), 1'b1, core_rsp.gnt);
      data = $random(seed);
      access(1'b1, BeWidth'(be), word, data);
      model[word] = merge_bytes(model[word], data, BeWidth'(be));
      // Merge write occupies the bank unless all bytes were enabled
      check_flag($sformatf("partial[%0d] gnt after store", be), be == 15, core_rsp.gnt);
      read_check($sformatf("partial[%0d]", be), word, 1'b0, 1'b0, 1'b1);
    end
  endtask

  task automatic test_single_error();
    logic [AddrWidth-1:0] word;
    int unsigned          pos;
    for (int i = 0; i < NumT3; i++) begin
      word = AddrWidth'(rand_below(NumWords));
      write_full(word, $random(seed));
      pos = (i < NumT3 / 2) ? rand_below(DataWidth) : DataWidth + rand_below(CheckWidth);
      flip_bit(word, pos);
      read_check($sformatf("single_err[%0d] bit %0d", i, pos), word, 1'b1, 1'b0, 1'b1);
      write_full(word, model[word]);  // Leave no fault for the scrubber
    end
  endtask

  task automatic test_double_error();
    logic [AddrWidth-1:0] word;
    int unsigned          pos_a;
    int unsigned          pos_b;
    for (int i = 0; i < NumT4; i++) begin
      word  = AddrWidth'(rand_below(NumWords));
      write_full(word, $random(seed));
      pos_a = rand_below(CodeWidth);
      pos_b = (pos_a + 1 + rand_below(CodeWidth - 1)) % CodeWidth;
      flip_bit(word, pos_a);
      flip_bit(word, pos_b);
      read_check($sformatf("double_err[%0d]", i), word, 1'b0, 1'b1, 1'b0);
      write_full(word, model[word]);
    end
  endtask

  task automatic test_scrub_repair();
    logic [CountWidth-1:0] start_count;
    int                    cycles;
    @(negedge clk_i);
    core_req    = '0;  // Core idle, bank free for the scrubber
    start_count = scrub_count;
    flip_bit(AddrWidth'(3), rand_below(DataWidth));
    cycles = 0;
    while (scrub_count == start_count) begin
      cycles++;
      if (cycles > ScrubBound) stop_on_error("scrubber did not repair word 3 in time");
      @(negedge clk_i);
    end
    read_check("scrub_repair word 3", AddrWidth'(3), 1'b0, 1'b0, 1'b1);
    // One fault means exactly one rewrite
    check_count("scrub_repair count", start_count + 1'b1, scrub_count);
  endtask

  task automatic test_core_priority();
    logic [CountWidth-1:0] start_count;
    @(negedge clk_i);
    core_req    = idle_req();
    start_count = scrub_count;
    flip_bit(AddrWidth'(4), rand_below(DataWidth));  // Next word on the scrubber's walk
    repeat (2 * ScrubInterval) @(negedge clk_i);
    check_count("core_priority count", start_count, scrub_count);
    // Fault is still in place since the scrubber never got the bank
    read_check("core_priority word 4", AddrWidth'(4), 1'b1, 1'b0, 1'b1);
  endtask

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk_i);
    stop_on_error("watchdog expired before the tests finished");
  end

  initial begin
    seed     = 32'h3cca;
    rst_ni   = 1'b0;
    core_req = idle_req();
    for (int i = 0; i < NumWords; i++) begin
      model[i] = '0;  // Bank powers up as zero codewords
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_full_words();
    test_partial_writes();
    test_single_error();
    test_double_error();
    test_scrub_repair();
    test_core_priority();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- src/ecc_mem_top.sv
`timescale 1ns/1ps
// ECC data memory top
// Core port and scrubber share one protected bank through the arbiter
module ecc_mem_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  ecc_mem_pkg::mem_req_t              core_req_i,
  output ecc_mem_pkg::mem_rsp_t              core_rsp_o,
  output logic [ecc_mem_pkg::CountWidth-1:0] scrub_count_o
);
  import ecc_mem_pkg::*;

  mem_req_t scrub_req;
  mem_rsp_t scrub_rsp;
  mem_req_t bank_req;   // Arbiter to wrapper
  mem_rsp_t bank_rsp;

  bank_arbiter bank_arbiter_i (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .core_req_i  ( core_req_i ),
    .scrub_req_i ( scrub_req  ),
    .core_rsp_o  ( core_rsp_o ),
    .scrub_rsp_o ( scrub_rsp  ),
    .bank_req_o  ( bank_req   ),
    .bank_rsp_i  ( bank_rsp   )
  );

  ecc_scrubber ecc_scrubber_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .req_o         ( scrub_req     ),
    .rsp_i         ( scrub_rsp     ),
    .scrub_count_o ( scrub_count_o )
  );

  ecc_bank_wrap ecc_bank_wrap_i (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .req_i  ( bank_req ),
    .rsp_o  ( bank_rsp )
  );

endmodule

//--- src/ecc_scrubber.sv
`timescale 1ns/1ps
// Background ECC scrubber
// Reads one word per interval and rewrites it when a single error was corrected
module ecc_scrubber (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  output ecc_mem_pkg::mem_req_t              req_o,
  input  ecc_mem_pkg::mem_rsp_t              rsp_i,
  output logic [ecc_mem_pkg::CountWidth-1:0] scrub_count_o
);
  import ecc_mem_pkg::*;

  scrub_state_e state_d, state_q;

  logic [ScrubCntWidth-1:0] wait_cnt_d, wait_cnt_q;
  logic [AddrWidth-1:0]     addr_d, addr_q;
  logic [AddrWidth-1:0]     next_addr;
  logic [CountWidth-1:0]    count_d, count_q;
  logic [DataWidth-1:0]     fix_data_q;  // Corrected word to write back
  logic                     fix_load;

  assign next_addr = (addr_q == AddrWidth'(NumWords - 1)) ? '0 : addr_q + 1'b1;

  always_comb begin
    state_d    = state_q;
    wait_cnt_d = wait_cnt_q;
    addr_d     = addr_q;
    count_d    = count_q;
    fix_load   = 1'b0;
    case (state_q)
      WAIT: begin
        if (wait_cnt_q == ScrubCntWidth'(ScrubInterval - 1)) begin
          wait_cnt_d = '0;
          state_d    = READ;
        end else begin
          wait_cnt_d = wait_cnt_q + 1'b1;
        end
      end
      READ: begin
        if (rsp_i.gnt) state_d = CHECK;  // Data arrives next cycle
      end
      CHECK: begin
        if (rsp_i.err_corr && !rsp_i.err_uncorr) begin
          fix_load = 1'b1;
          state_d  = FIX;
        end else begin
          addr_d  = next_addr;
          state_d = WAIT;
        end
      end
      FIX: begin
        if (rsp_i.gnt) begin
          if (count_q != '1) count_d = count_q + 1'b1;  // Saturates
          addr_d  = next_addr;
          state_d = WAIT;
        end
      end
      default: state_d = WAIT;
    endcase
  end

  assign req_o.req   = (state_q == READ) || (state_q == FIX);
  assign req_o.we    = (state_q == FIX);
  assign req_o.be    = '1;                                // Always full word
  assign req_o.addr  = {{(BusAddrWidth-AddrWidth-2){1'b0}}, addr_q, 2'b00};
  assign req_o.wdata = fix_data_q;

  assign scrub_count_o = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= WAIT;
      wait_cnt_q <= '0;
      addr_q     <= '0;
      count_q    <= '0;
    end else begin
      state_q    <= state_d;
      wait_cnt_q <= wait_cnt_d;
      addr_q     <= addr_d;
      count_q    <= count_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fix_load) fix_data_q <= rsp_i.rdata;
  end

endmodule

//--- src/bank_arbiter.sv
`timescale 1ns/1ps
// Fixed-priority bank arbiter
// Core port wins over the scrubber; read responses follow the read's owner
module bank_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ecc_mem_pkg::mem_req_t core_req_i,
  input  ecc_mem_pkg::mem_req_t scrub_req_i,
  output ecc_mem_pkg::mem_rsp_t core_rsp_o,
  output ecc_mem_pkg::mem_rsp_t scrub_rsp_o,
  output ecc_mem_pkg::mem_req_t bank_req_o,
  input  ecc_mem_pkg::mem_rsp_t bank_rsp_i
);

  logic core_sel;
  logic rd_accept;
  logic owner_scrub_q;  // Last accepted read came from the scrubber

  assign core_sel   = core_req_i.req;
  assign bank_req_o = core_sel ? core_req_i : scrub_req_i;
  assign rd_accept  = bank_req_o.req & ~bank_req_o.we & bank_rsp_i.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_scrub_q <= 1'b0;
    end else if (rd_accept) begin
      owner_scrub_q <= ~core_sel;
    end
  end

  always_comb begin
    core_rsp_o      = bank_rsp_i;
    scrub_rsp_o     = bank_rsp_i;
    core_rsp_o.gnt  = bank_rsp_i.gnt & core_sel;
    scrub_rsp_o.gnt = bank_rsp_i.gnt & ~core_sel;
    // Non-owner sees a quiet response
    if (owner_scrub_q) begin
      core_rsp_o.rdata      = '0;
      core_rsp_o.err_corr   = 1'b0;
      core_rsp_o.err_uncorr = 1'b0;
    end else begin
      scrub_rsp_o.rdata      = '0;
      scrub_rsp_o.err_corr   = 1'b0;
      scrub_rsp_o.err_uncorr = 1'b0;
    end
  end

endmodule

//--- src/ecc_bank_wrap.sv
`timescale 1ns/1ps
// ECC bank wrapper
// Stores words as SECDED codewords; partial stores become a read
// followed by a merged write in the next cycle
module ecc_bank_wrap (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ecc_mem_pkg::mem_req_t req_i,
  output ecc_mem_pkg::mem_rsp_t rsp_o
);
  import ecc_mem_pkg::*;

  store_state_e state_d, state_q;

  logic                 bank_req;
  logic                 bank_we;
  logic [AddrWidth-1:0] bank_addr;
  logic [CodeWidth-1:0] bank_wdata;
  logic [CodeWidth-1:0] bank_rdata;

  logic [DataWidth-1:0] to_store;
  logic [DataWidth-1:0] loaded;
  logic                 err_single;
  logic                 err_double;
  logic [DataWidth-1:0] be_mask;
  logic                 partial_wr;
  logic                 rd_accept;
  logic                 rd_valid_q;   // Peer read response due this cycle

  logic [AddrWidth-1:0] addr_buf_q;
  logic [DataWidth-1:0] wdata_buf_q;
  logic [BeWidth-1:0]   be_buf_q;

  sram_bank sram_bank_i (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( bank_req   ),
    .we_i    ( bank_we    ),
    .addr_i  ( bank_addr  ),
    .wdata_i ( bank_wdata ),
    .rdata_o ( bank_rdata )
  );

  secded_39_32_dec secded_dec_i (
    .code_i       ( bank_rdata ),
    .data_o       ( loaded     ),
    .syndrome_o   (            ),
    .err_single_o ( err_single ),
    .err_double_o ( err_double )
  );

  secded_39_32_enc secded_enc_i (
    .data_i ( to_store   ),
    .code_o ( bank_wdata )
  );

  assign partial_wr = req_i.req & req_i.we & (req_i.be != '1) & (state_q == NORMAL);
  assign rd_accept  = req_i.req & ~req_i.we & (state_q == NORMAL);

  // Byte enables widened to bit lanes
  always_comb begin
    for (int b = 0; b < BeWidth; b++) begin
      be_mask[8*b +: 8] = {8{be_buf_q[b]}};
    end
  end

  always_comb begin
    state_d   = state_q;
    bank_req  = req_i.req;
    bank_we   = req_i.we;
    bank_addr = req_i.addr[AddrWidth+1:2];
    to_store  = req_i.wdata;
    if (state_q == NORMAL) begin
      if (partial_wr) begin
        state_d = LOAD_AND_STORE;
        bank_we = 1'b0;                      // Fetch the old word first
      end
    end else begin
      state_d   = NORMAL;
      bank_req  = 1'b1;
      bank_we   = 1'b1;
      bank_addr = addr_buf_q;
      to_store  = (be_mask & wdata_buf_q) | (~be_mask & loaded);
    end
  end

  // Bank is busy during the merge write
  assign rsp_o.gnt        = req_i.req & (state_q == NORMAL);
  assign rsp_o.rdata      = loaded;
  assign rsp_o.err_corr   = rd_valid_q & err_single;
  assign rsp_o.err_uncorr = rd_valid_q & err_double;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= NORMAL;
      rd_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_valid_q <= rd_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (partial_wr) begin
      addr_buf_q  <= req_i.addr[AddrWidth+1:2];
      wdata_buf_q <= req_i.wdata;
      be_buf_q    <= req_i.be;
    end
  end

endmodule

//--- src/sram_bank.sv
`timescale 1ns/1ps
// Single-port codeword memory, one cycle read latency
module sram_bank (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [ecc_mem_pkg::AddrWidth-1:0] addr_i,
  input  logic [ecc_mem_pkg::CodeWidth-1:0] wdata_i,
  output logic [ecc_mem_pkg::CodeWidth-1:0] rdata_o
);
  import ecc_mem_pkg::*;

  logic [CodeWidth-1:0] mem [NumWords];

  // All-zero words decode cleanly
  initial begin
    for (int i = 0; i < NumWords; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];  // Held until the next read
    end
  end

endmodule

//--- src/secded_39_32_dec.sv
`timescale 1ns/1ps
// SECDED decoder for 39-bit codewords
// Corrects one flipped data bit and flags single and double errors
module secded_39_32_dec (
  input  logic [ecc_mem_pkg::CodeWidth-1:0]  code_i,
  output logic [ecc_mem_pkg::DataWidth-1:0]  data_o,
  output logic [ecc_mem_pkg::CheckWidth-1:0] syndrome_o,
  output logic                               err_single_o,
  output logic                               err_double_o
);
  import ecc_mem_pkg::*;

  logic [CheckWidth-1:0] check_calc;
  logic [CheckWidth-1:0] syndrome;

  // Recompute check bits from the stored data
  always_comb begin
    check_calc = '0;
    for (int i = 0; i < DataWidth; i++) begin
      check_calc ^= HsiaoCol[i] & {CheckWidth{code_i[i]}};
    end
  end

  assign syndrome = check_calc ^ code_i[CodeWidth-1:DataWidth];

  // Flip the data bit whose column matches the syndrome
  always_comb begin
    for (int i = 0; i < DataWidth; i++) begin
      data_o[i] = code_i[i] ^ (syndrome == HsiaoCol[i]);
    end
  end

  // Odd weight means one error; check bit hits are included here
  assign err_single_o = ^syndrome;
  assign err_double_o = (syndrome != '0) & ~(^syndrome);
  assign syndrome_o   = syndrome;

endmodule

//--- src/secded_39_32_enc.sv
`timescale 1ns/1ps
// SECDED encoder for 32-bit data
// Appends seven Hsiao check bits above the data word
module secded_39_32_enc (
  input  logic [ecc_mem_pkg::DataWidth-1:0] data_i,
  output logic [ecc_mem_pkg::CodeWidth-1:0] code_o
);
  import ecc_mem_pkg::*;

  logic [CheckWidth-1:0] check;

  // Each set data bit toggles the check bits of its column
  always_comb begin
    check = '0;
    for (int i = 0; i < DataWidth; i++) begin
      check ^= HsiaoCol[i] & {CheckWidth{data_i[i]}};
    end
  end

  assign code_o = {check, data_i};  // Check bits on top

endmodule

//--- src/ecc_mem_pkg.sv
// ECC data memory package
// Sizes, bus request and response structs, FSM states and the SECDED column table
package ecc_mem_pkg;

  localparam int DataWidth     = 32;
  localparam int CheckWidth    = 7;
  localparam int CodeWidth     = DataWidth + CheckWidth;  // 39-bit codeword
  localparam int BeWidth       = DataWidth / 8;
  localparam int NumWords      = 256;
  localparam int AddrWidth     = $clog2(NumWords);        // Word address
  localparam int BusAddrWidth  = 32;                      // Byte address on the bus
  localparam int ScrubInterval = 64;                      // Idle cycles between scrub reads
  localparam int ScrubCntWidth = $clog2(ScrubInterval);
  localparam int CountWidth    = 16;

  // Hsiao columns, one distinct weight-3 syndrome per data bit
  localparam logic [DataWidth-1:0][CheckWidth-1:0] HsiaoCol = {
    7'h62, 7'h61, 7'h58, 7'h54, 7'h52, 7'h51, 7'h4C, 7'h4A,
    7'h49, 7'h46, 7'h45, 7'h43, 7'h38, 7'h34, 7'h32, 7'h31,
    7'h2C, 7'h2A, 7'h29, 7'h26, 7'h25, 7'h23, 7'h1C, 7'h1A,
    7'h19, 7'h16, 7'h15, 7'h13, 7'h0E, 7'h0D, 7'h0B, 7'h07
  };

  typedef struct packed {
    logic                    req;
    logic                    we;     // 1 = write
    logic [BeWidth-1:0]      be;
    logic [BusAddrWidth-1:0] addr;
    logic [DataWidth-1:0]    wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 gnt;
    logic [DataWidth-1:0] rdata;
    logic                 err_corr;    // Single error fixed in rdata
    logic                 err_uncorr;  // Double error, rdata not usable
  } mem_rsp_t;

  typedef enum logic {
    NORMAL,
    LOAD_AND_STORE
  } store_state_e;

  typedef enum logic [1:0] {
    WAIT,
    READ,
    CHECK,
    FIX
  } scrub_state_e;

endpackage
